//--- rtl/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// --------------------
// Architectural widths
// --------------------

// Data and PC width
`define ISSUE_XLEN 32

// Register number width
`define ISSUE_RADDR_W 5

// One-hot ALU operation
`define ISSUE_ALU_OP_W 16

// --------------------
// Queue sizing
// --------------------

`define ISSUE_QUEUE_DEPTH 8
// Free entries left when back-pressure rises
`define ISSUE_FULL_MARGIN 2

`endif

//--- rtl/issue_pkg.sv
`include "issue_params.svh"

package issue_pkg;

    typedef logic [`ISSUE_XLEN-1:0]     word_t;
    typedef logic [`ISSUE_RADDR_W-1:0]  reg_addr_t;
    typedef logic [`ISSUE_ALU_OP_W-1:0] alu_op_t;

    // --------------------
    // Decoded instruction
    // --------------------
    typedef struct packed {
        alu_op_t   alu_op;
        word_t     imm;
        word_t     pc;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_branch;
        logic      pred_taken;
    } inst_t;

    // One queue entry
    typedef struct packed {
        inst_t inst1;
        inst_t inst2;
    } pair_t;

    // Result bypass from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    // Issued instruction with resolved operands
    typedef struct packed {
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        word_t     pc;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
        logic      is_branch;
        logic      pred_taken;
    } pipe_out_t;

    typedef enum logic {
        ST_PAIR,
        ST_SECOND
    } issue_state_e;

endpackage

//--- rtl/pair_queue.sv
`timescale 1ns/10ps
`include "issue_params.svh"

module pair_queue
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  pair_t pair_i,
    input  logic  pop_i,
    output pair_t head_o,
    output logic  empty_o,
    output logic  almost_full_o,
    output logic  full_o
);

    localparam int PTR_W = $clog2(`ISSUE_QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    pair_t            mem [`ISSUE_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pushes into a full queue are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign head_o        = mem[rd_ptr];
    assign empty_o       = (count == '0);
    assign full_o        = (count == CNT_W'(`ISSUE_QUEUE_DEPTH));
    assign almost_full_o = (CNT_W'(`ISSUE_QUEUE_DEPTH) - count) <= CNT_W'(`ISSUE_FULL_MARGIN);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= pair_i;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`ISSUE_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`ISSUE_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- rtl/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  pair_t head_i,
    input  logic  empty_i,
    input  logic  stall_i,
    input  logic  fu1_ready_i,
    input  logic  fu2_ready_i,
    output logic  pop_o,
    output logic  valid1_o,
    output logic  valid2_o,
    output inst_t slot1_o,
    output inst_t slot2_o
);

    issue_state_e state;
    issue_state_e state_nxt;

    logic raw_hazard;
    logic mem_access;
    logic has_branch;
    logic dual_ok;
    logic dual_take;
    logic single_take;
    logic inst1_pred_br;
    logic inst2_reads_rk;

    // --------------------
    // Pair hazard check
    // --------------------
    assign inst2_reads_rk = !head_i.inst2.src2_is_imm || head_i.inst2.mem_we;

    // Writes to r0 never create a dependency
    assign raw_hazard = head_i.inst1.gr_we && (head_i.inst1.dest != '0) &&
                        (((head_i.inst1.dest == head_i.inst2.rj) &&
                          !head_i.inst2.src1_is_pc) ||
                         ((head_i.inst1.dest == head_i.inst2.rk) && inst2_reads_rk));

    assign mem_access = head_i.inst1.mem_we || head_i.inst1.res_from_mem ||
                        head_i.inst2.mem_we || head_i.inst2.res_from_mem;

    assign has_branch = head_i.inst1.is_branch || head_i.inst2.is_branch;

    assign dual_ok = !raw_hazard && !mem_access && !has_branch;

    assign inst1_pred_br = head_i.inst1.is_branch && head_i.inst1.pred_taken;

    // Acceptance by the execution pipes
    assign dual_take   = !stall_i && fu1_ready_i && fu2_ready_i;
    assign single_take = !stall_i && fu1_ready_i;

    // --------------------
    // Slot select and pop
    // --------------------
    always_comb begin
        state_nxt = state;
        pop_o     = 1'b0;
        valid1_o  = 1'b0;
        valid2_o  = 1'b0;
        slot1_o   = head_i.inst1;
        slot2_o   = head_i.inst2;
        case (state)
            ST_PAIR: begin
                valid1_o = !empty_i;
                valid2_o = !empty_i && dual_ok;
                if (!empty_i) begin
                    if (dual_ok) begin
                        pop_o = dual_take;
                    end else if (single_take) begin
                        // Second instruction is on the wrong path
                        if (inst1_pred_br) begin
                            pop_o = 1'b1;
                        end else begin
                            state_nxt = ST_SECOND;
                        end
                    end
                end
            end
            ST_SECOND: begin
                // inst2 moves to pipe 1
                slot1_o  = head_i.inst2;
                valid1_o = !empty_i;
                if (!empty_i && single_take) begin
                    pop_o     = 1'b1;
                    state_nxt = ST_PAIR;
                end
            end
            default: begin
                state_nxt = ST_PAIR;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_PAIR;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- rtl/operand_read.sv
`timescale 1ns/10ps

module operand_read
    import issue_pkg::*;
(
    input  inst_t           slot1_i,
    input  inst_t           slot2_i,
    input  logic            valid1_i,
    input  logic            valid2_i,
    // Index 0 ex2, 1 ex1, 2 mem2, 3 mem1
    input  fwd_t      [3:0] fwd_i,
    input  word_t     [3:0] rf_rdata_i,
    output reg_addr_t [3:0] rf_raddr_o,
    output logic      [3:0] rf_re_o,
    output pipe_out_t       pipe1_o,
    output pipe_out_t       pipe2_o
);

    inst_t     slot  [2];
    logic      valid [2];
    pipe_out_t built [2];

    // --------------------
    // Forwarding priority
    // --------------------
    function automatic word_t fwd_pick(reg_addr_t addr, word_t rf_data, fwd_t [3:0] srcs);
        word_t res;
        logic  hit;
        res = rf_data;
        hit = 1'b0;
        // Youngest stage first
        for (int i = 0; i < 4; i++) begin
            if (!hit && srcs[i].we && (srcs[i].waddr == addr)) begin
                res = srcs[i].wdata;
                hit = 1'b1;
            end
        end
        if (addr == '0) begin
            res = '0;
        end
        return res;
    endfunction

    function automatic pipe_out_t build_pipe(inst_t inst, word_t rdata_j, word_t rdata_k,
                                             fwd_t [3:0] srcs);
        pipe_out_t po;
        word_t     val_j;
        word_t     val_k;
        val_j           = fwd_pick(inst.rj, rdata_j, srcs);
        val_k           = fwd_pick(inst.rk, rdata_k, srcs);
        po.alu_op       = inst.alu_op;
        po.src1         = inst.src1_is_pc ? inst.pc : val_j;
        po.src2         = inst.src2_is_imm ? inst.imm : val_k;
        po.store_data   = val_k;
        po.pc           = inst.pc;
        po.dest         = inst.dest;
        po.gr_we        = inst.gr_we;
        po.mem_we       = inst.mem_we;
        po.res_from_mem = inst.res_from_mem;
        po.is_branch    = inst.is_branch;
        po.pred_taken   = inst.pred_taken;
        return po;
    endfunction

    assign slot[0]  = slot1_i;
    assign slot[1]  = slot2_i;
    assign valid[0] = valid1_i;
    assign valid[1] = valid2_i;

    // --------------------
    // Read ports
    // --------------------
    // Ports 0/1 serve pipe 1, ports 2/3 serve pipe 2
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rf_raddr_o[2*p]   = valid[p] ? slot[p].rj : '0;
            rf_raddr_o[2*p+1] = valid[p] ? slot[p].rk : '0;
            rf_re_o[2*p]      = valid[p] && !slot[p].src1_is_pc && (slot[p].rj != '0);
            rf_re_o[2*p+1]    = valid[p] && (!slot[p].src2_is_imm || slot[p].mem_we) &&
                                (slot[p].rk != '0);
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            built[p] = build_pipe(slot[p], rf_rdata_i[2*p], rf_rdata_i[2*p+1], fwd_i);
        end
    end

    // Idle pipe carries all zeros
    assign pipe1_o = valid1_i ? built[0] : '0;
    assign pipe2_o = valid2_i ? built[1] : '0;

endmodule

//--- rtl/issue_unit.sv
`timescale 1ns/10ps

module issue_unit
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid_i,
    input  pair_t           pair_i,
    output logic            full_o,
    input  logic            stall_i,
    input  logic            fu1_ready_i,
    input  logic            fu2_ready_i,
    input  fwd_t      [3:0] fwd_i,
    input  word_t     [3:0] rf_rdata_i,
    output reg_addr_t [3:0] rf_raddr_o,
    output logic      [3:0] rf_re_o,
    output logic            pipe1_valid_o,
    output logic            pipe2_valid_o,
    output pipe_out_t       pipe1_o,
    output pipe_out_t       pipe2_o
);

    pair_t head;
    logic  empty;
    logic  pop;
    inst_t slot1;
    inst_t slot2;

    // Decoder back-pressure is the almost-full flag
    pair_queue i_pair_queue (
        .clk           (clk),
        .rst           (rst),
        .push_i        (in_valid_i),
        .pair_i        (pair_i),
        .pop_i         (pop),
        .head_o        (head),
        .empty_o       (empty),
        .almost_full_o (full_o),
        .full_o        ()
    );

    issue_ctrl i_issue_ctrl (
        .clk         (clk),
        .rst         (rst),
        .head_i      (head),
        .empty_i     (empty),
        .stall_i     (stall_i),
        .fu1_ready_i (fu1_ready_i),
        .fu2_ready_i (fu2_ready_i),
        .pop_o       (pop),
        .valid1_o    (pipe1_valid_o),
        .valid2_o    (pipe2_valid_o),
        .slot1_o     (slot1),
        .slot2_o     (slot2)
    );

    operand_read i_operand_read (
        .slot1_i    (slot1),
        .slot2_i    (slot2),
        .valid1_i   (pipe1_valid_o),
        .valid2_i   (pipe2_valid_o),
        .fwd_i      (fwd_i),
        .rf_rdata_i (rf_rdata_i),
        .rf_raddr_o (rf_raddr_o),
        .rf_re_o    (rf_re_o),
        .pipe1_o    (pipe1_o),
        .pipe2_o    (pipe2_o)
    );

endmodule

//--- sim/issue_tb.sv
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_tb
    import issue_pkg::*;
();

    logic            clk;
    logic            rst;
    logic            in_valid;
    pair_t           pair_in;
    logic            full;
    logic            stall;
    logic            fu1_ready;
    logic            fu2_ready;
    fwd_t      [3:0] fwd;
    word_t     [3:0] rf_rdata;
    reg_addr_t [3:0] rf_raddr;
    logic      [3:0] rf_re;
    logic            pipe1_valid;
    logic            pipe2_valid;
    pipe_out_t       pipe1;
    pipe_out_t       pipe2;

    integer errors;
    integer seed;

    issue_unit i_issue_unit (
        .clk           (clk),
        .rst           (rst),
        .in_valid_i    (in_valid),
        .pair_i        (pair_in),
        .full_o        (full),
        .stall_i       (stall),
        .fu1_ready_i   (fu1_ready),
        .fu2_ready_i   (fu2_ready),
        .fwd_i         (fwd),
        .rf_rdata_i    (rf_rdata),
        .rf_raddr_o    (rf_raddr),
        .rf_re_o       (rf_re),
        .pipe1_valid_o (pipe1_valid),
        .pipe2_valid_o (pipe2_valid),
        .pipe1_o       (pipe1),
        .pipe2_o       (pipe2)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Register file model
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rf_rdata[p] = 32'h1000 + word_t'(rf_raddr[p]);
        end
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic word_t operand_value(reg_addr_t a);
        if (a == '0) return '0;
        if (fwd[0].we && fwd[0].waddr == a) return fwd[0].wdata;
        if (fwd[1].we && fwd[1].waddr == a) return fwd[1].wdata;
        if (fwd[2].we && fwd[2].waddr == a) return fwd[2].wdata;
        if (fwd[3].we && fwd[3].waddr == a) return fwd[3].wdata;
        return 32'h1000 + word_t'(a);
    endfunction

    function automatic pipe_out_t expect_pipe(inst_t in);
        pipe_out_t e;
        e              = '0;
        e.alu_op       = in.alu_op;
        e.src1         = in.src1_is_pc ? in.pc : operand_value(in.rj);
        e.src2         = in.src2_is_imm ? in.imm : operand_value(in.rk);
        e.store_data   = operand_value(in.rk);
        e.pc           = in.pc;
        e.dest         = in.dest;
        e.gr_we        = in.gr_we;
        e.mem_we       = in.mem_we;
        e.res_from_mem = in.res_from_mem;
        e.is_branch    = in.is_branch;
        e.pred_taken   = in.pred_taken;
        return e;
    endfunction

    function automatic inst_t make_alu(word_t pc, reg_addr_t rj, reg_addr_t rk,
                                       reg_addr_t dest, logic s1pc, logic s2imm);
        inst_t i;
        i             = '0;
        i.alu_op      = 16'h0001;
        i.imm         = $random(seed);
        i.pc          = pc;
        i.rj          = rj;
        i.rk          = rk;
        i.dest        = dest;
        i.gr_we       = (dest != '0);
        i.src1_is_pc  = s1pc;
        i.src2_is_imm = s2imm;
        return i;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_pipe(string name, pipe_out_t got, pipe_out_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // Drive helpers
    // --------------------
    task automatic push_pair(pair_t p);
        @(posedge clk);
        in_valid <= 1'b1;
        pair_in  <= p;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_valid1();
        integer n;
        n = 0;
        @(negedge clk);
        while (!pipe1_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!pipe1_valid) begin
            $display("Timeout waiting for pipe 1 to offer an instruction");
            errors++;
        end
    endtask

    // One accepted issue; dual when both pipes ready
    task automatic accept(logic dual);
        @(posedge clk);
        fu1_ready <= 1'b1;
        fu2_ready <= dual;
        @(posedge clk);
        fu1_ready <= 1'b0;
        fu2_ready <= 1'b0;
        @(negedge clk);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_dual();
        pair_t p;
        p.inst1 = make_alu(32'h100, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0);
        p.inst2 = make_alu(32'h104, 5'd4, 5'd5, 5'd6, 1'b1, 1'b1);
        push_pair(p);
        wait_valid1();
        check_bit("pipe2_valid", pipe2_valid, 1'b1);
        check_pipe("pipe1", pipe1, expect_pipe(p.inst1));
        check_pipe("pipe2", pipe2, expect_pipe(p.inst2));
        check_addr("rf_raddr0", rf_raddr[0], 5'd1);
        check_addr("rf_raddr1", rf_raddr[1], 5'd2);
        check_addr("rf_raddr2", rf_raddr[2], 5'd4);
        check_bit("rf_re0", rf_re[0], 1'b1);
        check_bit("rf_re1", rf_re[1], 1'b1);
        check_bit("rf_re2", rf_re[2], 1'b0);
        check_bit("rf_re3", rf_re[3], 1'b0);
        accept(1'b1);
        check_bit("pipe1_valid", pipe1_valid, 1'b0);
    endtask

    task automatic test_split(logic use_load);
        pair_t p;
        p.inst1 = make_alu(32'h200, 5'd1, 5'd2, 5'd5, 1'b0, 1'b0);
        if (use_load) begin
            p.inst2              = make_alu(32'h204, 5'd8, 5'd0, 5'd9, 1'b0, 1'b1);
            p.inst2.res_from_mem = 1'b1;
        end else begin
            p.inst2 = make_alu(32'h204, 5'd5, 5'd3, 5'd9, 1'b0, 1'b0);
        end
        push_pair(p);
        wait_valid1();
        check_bit("pipe2_valid", pipe2_valid, 1'b0);
        check_pipe("pipe1", pipe1, expect_pipe(p.inst1));
        check_pipe("pipe2", pipe2, '0);
        accept(1'b1);
        wait_valid1();
        check_pipe("pipe1", pipe1, expect_pipe(p.inst2));
        check_pipe("pipe2", pipe2, '0);
        accept(1'b0);
        check_bit("pipe1_valid", pipe1_valid, 1'b0);
    endtask

    task automatic test_pred_branch();
        pair_t a;
        pair_t b;
        a.inst1            = make_alu(32'h300, 5'd1, 5'd2, 5'd0, 1'b0, 1'b0);
        a.inst1.is_branch  = 1'b1;
        a.inst1.pred_taken = 1'b1;
        a.inst2            = make_alu(32'h304, 5'd3, 5'd4, 5'd7, 1'b0, 1'b0);
        b.inst1            = make_alu(32'h400, 5'd10, 5'd11, 5'd12, 1'b0, 1'b1);
        b.inst2            = make_alu(32'h404, 5'd13, 5'd14, 5'd15, 1'b0, 1'b0);
        push_pair(a);
        push_pair(b);
        wait_valid1();
        check_pipe("pipe1", pipe1, expect_pipe(a.inst1));
        check_bit("pipe2_valid", pipe2_valid, 1'b0);
        accept(1'b0);
        check_pipe("pipe1", pipe1, expect_pipe(b.inst1));
        check_pipe("pipe2", pipe2, expect_pipe(b.inst2));
        check_addr("rf_raddr3", rf_raddr[3], 5'd14);
        check_bit("rf_re3", rf_re[3], 1'b1);
        accept(1'b1);
        check_bit("pipe1_valid", pipe1_valid, 1'b0);
    endtask

    task automatic test_forward();
        pair_t p;
        p.inst1 = make_alu(32'h500, 5'd7, 5'd7, 5'd8, 1'b0, 1'b0);
        p.inst2 = make_alu(32'h504, 5'd0, 5'd7, 5'd9, 1'b0, 1'b0);
        @(posedge clk);
        fwd[0] <= '{we: 1'b1, waddr: 5'd7, wdata: 32'hE2E2_0000};
        fwd[1] <= '{we: 1'b1, waddr: 5'd7, wdata: 32'hE1E1_0000};
        fwd[2] <= '{we: 1'b1, waddr: 5'd7, wdata: 32'hB2B2_0000};
        fwd[3] <= '{we: 1'b1, waddr: 5'd7, wdata: 32'hB1B1_0000};
        push_pair(p);
        wait_valid1();
        // Peel sources off from the youngest down
        for (int s = 0; s < 5; s++) begin
            check_pipe("pipe1", pipe1, expect_pipe(p.inst1));
            check_pipe("pipe2", pipe2, expect_pipe(p.inst2));
            if (s < 4) begin
                @(posedge clk);
                fwd[s].we <= 1'b0;
                @(negedge clk);
            end
        end
        // A bypass aimed at r0 must not leak through
        @(posedge clk);
        fwd[0] <= '{we: 1'b1, waddr: 5'd0, wdata: 32'hDEAD_BEEF};
        @(negedge clk);
        check_pipe("pipe2", pipe2, expect_pipe(p.inst2));
        accept(1'b1);
        @(posedge clk);
        fwd <= '0;
    endtask

    task automatic test_backpressure();
        pair_t p;
        pair_t q [$];
        p.inst1 = make_alu(32'h600, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0);
        p.inst2 = make_alu(32'h604, 5'd4, 5'd5, 5'd6, 1'b0, 1'b0);
        push_pair(p);
        wait_valid1();
        @(posedge clk);
        stall     <= 1'b1;
        fu1_ready <= 1'b1;
        fu2_ready <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("pipe1_valid", pipe1_valid, 1'b1);
            check_pipe("pipe1", pipe1, expect_pipe(p.inst1));
            check_pipe("pipe2", pipe2, expect_pipe(p.inst2));
        end
        @(posedge clk);
        stall     <= 1'b0;
        fu1_ready <= 1'b0;
        fu2_ready <= 1'b0;
        accept(1'b1);
        // Fill without issuing
        for (int k = 0; k < `ISSUE_QUEUE_DEPTH - `ISSUE_FULL_MARGIN; k++) begin
            p.inst1 = make_alu(32'h700 + word_t'(16 * k), 5'd1, 5'd2, 5'd3, 1'b0, 1'b0);
            p.inst2 = make_alu(32'h704 + word_t'(16 * k), 5'd4, 5'd5, 5'd6, 1'b0, 1'b0);
            q.push_back(p);
            @(negedge clk);
            check_bit("full_o", full, 1'b0);
            push_pair(p);
        end
        @(negedge clk);
        check_bit("full_o", full, 1'b1);
        while (q.size() > 0) begin
            p = q.pop_front();
            wait_valid1();
            check_pipe("pipe1", pipe1, expect_pipe(p.inst1));
            accept(1'b1);
        end
        check_bit("pipe1_valid", pipe1_valid, 1'b0);
        check_bit("full_o", full, 1'b0);
    endtask

    initial begin
        errors    = 0;
        seed      = 24223;
        rst       = 1'b1;
        in_valid  = 1'b0;
        pair_in   = '0;
        stall     = 1'b0;
        fu1_ready = 1'b0;
        fu2_ready = 1'b0;
        fwd       = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("pipe1_valid", pipe1_valid, 1'b0);
        check_bit("pipe2_valid", pipe2_valid, 1'b0);
        check_bit("full_o", full, 1'b0);
        check_bit("rf_re_any", |rf_re, 1'b0);

        test_dual();
        test_split(1'b0);
        test_split(1'b1);
        test_pred_branch();
        test_forward();
        test_backpressure();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/pair_queue.sv
rtl/issue_ctrl.sv
rtl/operand_read.sv
rtl/issue_unit.sv
sim/issue_tb.sv

//--- run.sh
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module issue_tb -o issue_sim

out=$(./obj_dir/issue_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
